// File: carry_lane_step.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Carry rule for a single symbol
// ---------------------------------------------------------------------------
module carry_lane_step (
    input  carry_pkg::symbol_t          sym,
    input  logic                        has_pending,
    input  logic [`CARRY_BYTE_W-1:0]    pending,
    input  logic [`CARRY_RUN_W-1:0]     run,
    output carry_pkg::emit_slot_t       lit,
    output carry_pkg::emit_slot_t       run_out,
    output logic                        next_has_pending,
    output logic [`CARRY_BYTE_W-1:0]    next_pending,
    output logic [`CARRY_RUN_W-1:0]     next_run
);
    import carry_pkg::*;

    logic [`CARRY_BYTE_W-1:0] lit_value;
    logic                     sym_is_ff;

    // The carry lands one place above its own byte, in the pending byte
    assign lit_value = pending + `CARRY_BYTE_W'(sym.carry);
    assign sym_is_ff = (sym.data == '1);

    always_comb begin
        lit              = EMPTY_SLOT;
        run_out          = EMPTY_SLOT;
        next_has_pending = 1'b1;
        next_pending     = pending;
        next_run         = run;

        if (!has_pending) begin
            // First byte of a stream, nothing below it to release yet
            next_pending = sym.data;
            next_run     = '0;
        end else if (sym_is_ff && !sym.carry) begin
            // A later carry could still ripple through this byte, so hold it
            next_run = run + 1'b1;
        end else begin
            // The carry is known now, so the pending byte and the run are final
            lit = make_lit(lit_value);
            if (run != '0) begin
                run_out = make_run(sym.carry, run);
            end
            next_pending = sym.data;
            next_run     = '0;
        end
    end

endmodule

`default_nettype wire

// File: carry_patterns.txt
# I first final count sym0 sym1 : one input cycle, symbols are {carry, byte} in hex
# E name n bytes : the stream that just ended, its byte count and expected bytes in hex
I 1 0 1 012 000
I 0 0 1 034 000
I 0 0 1 056 000
I 0 1 1 078 000
E lit_single 4 12 34 56 78
I 1 0 1 010 000
I 0 0 1 120 000
I 0 0 2 030 140
I 0 1 1 050 000
E carry_lit 5 11 20 31 40 50
I 1 0 1 005 000
I 0 0 1 0ff 000
I 0 0 1 0ff 000
I 0 0 1 0ff 000
I 0 1 2 007 008
E ff_run_nocarry 6 05 ff ff ff 07 08
I 1 0 2 02a 0ff
I 0 0 1 0ff 000
I 0 0 1 11b 000
I 0 1 1 00c 000
E ff_run_carry 5 2b 00 00 1b 0c
I 1 0 1 040 000
I 0 0 2 0ff 041
I 0 0 2 042 0ff
I 0 1 2 0ff 143
E two_lane_ff 7 40 ff 41 43 00 00 43
I 1 0 1 040 000
I 0 0 1 0ff 000
I 0 0 1 041 000
I 0 0 1 042 000
I 0 0 1 0ff 000
I 0 0 1 0ff 000
I 0 1 1 143 000
E one_lane_ff 7 40 ff 41 43 00 00 43
I 1 0 1 060 000
I 0 0 2 0ff 0ff
I 0 1 1 0ff 000
E flush_run 4 60 ff ff ff
I 1 1 2 081 182
E first_and_final 2 82 82
I 1 0 1 030 000
I 0 0 1 0ff 000
I 0 1 1 1ff 000
E carry_into_ff 3 31 00 ff

// File: carry_pkg.sv
`default_nettype none

`include "carry_settings.svh"

package carry_pkg;

    // Coded symbol as it leaves the arithmetic stage
    typedef struct packed {
        logic                     carry;
        logic [`CARRY_BYTE_W-1:0] data;
    } symbol_t;

    // What an output slot stands for
    typedef enum logic [1:0] {
        SLOT_NONE   = 2'd0,
        SLOT_LIT    = 2'd1,
        SLOT_RUN_FF = 2'd2,
        SLOT_RUN_00 = 2'd3
    } slot_kind_e;

    // The payload word is a byte for a literal and a count for a run
    typedef union packed {
        logic [`CARRY_BYTE_W-1:0] lit_byte;
        logic [`CARRY_RUN_W-1:0]  run_len;
    } slot_payload_u;

    typedef struct packed {
        slot_kind_e    kind;
        slot_payload_u payload;
    } emit_slot_t;

    localparam emit_slot_t EMPTY_SLOT = '0;

    function automatic emit_slot_t make_lit(input logic [`CARRY_BYTE_W-1:0] value);
        emit_slot_t s;
        s.kind             = SLOT_LIT;
        s.payload.lit_byte = value;
        return s;
    endfunction

    // A carry through the run turns every 0xFF of it into 0x00
    function automatic emit_slot_t make_run(input logic zeros,
                                            input logic [`CARRY_RUN_W-1:0] len);
        emit_slot_t s;
        s.kind            = zeros ? SLOT_RUN_00 : SLOT_RUN_FF;
        s.payload.run_len = len;
        return s;
    endfunction

endpackage

`default_nettype wire

// File: carry_resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Pending byte and 0xFF run state, two chained lanes and the final flush
// ---------------------------------------------------------------------------
module carry_resolver (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic                in_first,
    input  logic                in_final,
    input  logic [1:0]          in_count,
    input  carry_pkg::symbol_t  in_sym0,
    input  carry_pkg::symbol_t  in_sym1,
    release_if.src              rel
);
    import carry_pkg::*;

    logic                     has_pending_q;
    logic [`CARRY_BYTE_W-1:0] pending_q;
    logic [`CARRY_RUN_W-1:0]  run_q;

    logic                     lane0_has_pending;
    emit_slot_t               lane0_lit;
    emit_slot_t               lane0_run;
    logic                     lane0_next_has_pending;
    logic [`CARRY_BYTE_W-1:0] lane0_next_pending;
    logic [`CARRY_RUN_W-1:0]  lane0_next_run;

    emit_slot_t               lane1_lit;
    emit_slot_t               lane1_run;
    logic                     lane1_next_has_pending;
    logic [`CARRY_BYTE_W-1:0] lane1_next_pending;
    logic [`CARRY_RUN_W-1:0]  lane1_next_run;

    logic                     use_lane1;
    emit_slot_t               l1_lit;
    emit_slot_t               l1_run;
    logic                     post_has_pending;
    logic [`CARRY_BYTE_W-1:0] post_pending;
    logic [`CARRY_RUN_W-1:0]  post_run;

    emit_slot_t               flush_lit;
    emit_slot_t               flush_run;

    // A new stream forgets whatever the previous one left behind
    assign lane0_has_pending = has_pending_q & ~in_first;

    carry_lane_step lane0_step (
        .sym              (in_sym0),
        .has_pending      (lane0_has_pending),
        .pending          (pending_q),
        .run              (run_q),
        .lit              (lane0_lit),
        .run_out          (lane0_run),
        .next_has_pending (lane0_next_has_pending),
        .next_pending     (lane0_next_pending),
        .next_run         (lane0_next_run)
    );

    carry_lane_step lane1_step (
        .sym              (in_sym1),
        .has_pending      (lane0_next_has_pending),
        .pending          (lane0_next_pending),
        .run              (lane0_next_run),
        .lit              (lane1_lit),
        .run_out          (lane1_run),
        .next_has_pending (lane1_next_has_pending),
        .next_pending     (lane1_next_pending),
        .next_run         (lane1_next_run)
    );

    // One-lane cycles take the state straight from lane 0
    assign use_lane1        = (in_count == 2'd2);
    assign l1_lit           = use_lane1 ? lane1_lit : EMPTY_SLOT;
    assign l1_run           = use_lane1 ? lane1_run : EMPTY_SLOT;
    assign post_has_pending = use_lane1 ? lane1_next_has_pending : lane0_next_has_pending;
    assign post_pending     = use_lane1 ? lane1_next_pending : lane0_next_pending;
    assign post_run         = use_lane1 ? lane1_next_run : lane0_next_run;

    // No carry can follow the last byte, so the run is released as 0xFF
    always_comb begin
        flush_lit = EMPTY_SLOT;
        flush_run = EMPTY_SLOT;
        if (in_final && post_has_pending) begin
            flush_lit = make_lit(post_pending);
            if (post_run != '0) begin
                flush_run = make_run(1'b0, post_run);
            end
        end
    end

    assign rel.cand_strobe = in_valid;
    assign rel.cands       = {flush_run, flush_lit, l1_run, l1_lit, lane0_run, lane0_lit};

    // -----------------------------------------------------------------------
    // State
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            has_pending_q <= 1'b0;
            run_q         <= '0;
        end else if (in_valid) begin
            has_pending_q <= post_has_pending & ~in_final;
            run_q         <= in_final ? '0 : post_run;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            pending_q <= post_pending;
        end
    end

    // -----------------------------------------------------------------------
    // Checks
    // -----------------------------------------------------------------------
    // A run of 255 would wrap the counter, in either lane
    a_run_limit: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> (lane0_next_run != '1) && (post_run != '1));

    // The first byte of a stream has nothing below it to carry into
    a_no_orphan_carry: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !lane0_has_pending |-> !in_sym0.carry);

    a_lane_count: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid |-> in_count inside {2'd1, 2'd2});

endmodule

`default_nettype wire

// File: carry_settings.svh
`ifndef CARRY_SETTINGS_SVH
`define CARRY_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Carry-resolution stage sizing
// ---------------------------------------------------------------------------

// One output byte of the range coder
`define CARRY_BYTE_W 8

// A coded symbol is one carry bit above one byte
`define CARRY_SYM_W 9

// Counter for the held-back run of 0xFF bytes
`define CARRY_RUN_W 8

// Input lanes per cycle and output slots per cycle
`define CARRY_LANES 2
`define CARRY_SLOTS 4

// Two release candidates per lane plus two for the final flush
`define CARRY_CANDS 6

`endif

// File: carry_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Carry-resolution stage of the range coder byte output
// ---------------------------------------------------------------------------
module carry_top (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        in_valid,
    input  logic                                        in_first,
    input  logic                                        in_final,
    input  logic [1:0]                                  in_count,
    input  carry_pkg::symbol_t                          in_sym0,
    input  carry_pkg::symbol_t                          in_sym1,
    output logic                                        out_valid,
    output logic [2:0]                                  out_count,
    output carry_pkg::emit_slot_t [`CARRY_SLOTS-1:0]    out_slots
);

    release_if rel_bus ();

    // Combinational carry resolution, state updates on the accepting edge
    carry_resolver u_resolver (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_first (in_first),
        .in_final (in_final),
        .in_count (in_count),
        .in_sym0  (in_sym0),
        .in_sym1  (in_sym1),
        .rel      (rel_bus.src)
    );

    // One cycle of latency through the slot register
    slot_packer u_packer (
        .clk       (clk),
        .arst_n    (arst_n),
        .rel       (rel_bus.dst),
        .out_valid (out_valid),
        .out_count (out_count),
        .out_slots (out_slots)
    );

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
carry_pkg.sv
release_if.sv
carry_lane_step.sv
carry_resolver.sv
slot_packer.sv
carry_top.sv
tb_clock_gen.sv
tb_carry_checker.sv
tb_carry_top.sv

// File: release_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Release candidates from the resolver to the slot packer
// ---------------------------------------------------------------------------
interface release_if;
    import carry_pkg::*;

    // High in every cycle that the resolver accepts an input
    logic cand_strobe;

    // Stream order: lane 0 literal, lane 0 run, lane 1 literal,
    // lane 1 run, flush literal, flush run
    // Unused entries carry SLOT_NONE
    emit_slot_t [`CARRY_CANDS-1:0] cands;

    modport src (
        output cand_strobe,
        output cands
    );

    modport dst (
        input cand_strobe,
        input cands
    );

endinterface

`default_nettype wire

// File: slot_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Compacts release candidates into contiguous, registered output slots
// ---------------------------------------------------------------------------
module slot_packer (
    input  logic                                        clk,
    input  logic                                        arst_n,
    release_if.dst                                      rel,
    output logic                                        out_valid,
    output logic [2:0]                                  out_count,
    output carry_pkg::emit_slot_t [`CARRY_SLOTS-1:0]    out_slots
);
    import carry_pkg::*;

    emit_slot_t [`CARRY_SLOTS-1:0] slots_nxt;
    logic [2:0]                    count_nxt;

    // Walk the candidates in stream order and stack the used ones from slot 0
    always_comb begin
        slots_nxt = '0;
        count_nxt = '0;
        if (rel.cand_strobe) begin
            for (int i = 0; i < `CARRY_CANDS; i++) begin
                if (rel.cands[i].kind != SLOT_NONE) begin
                    if (count_nxt < `CARRY_SLOTS) begin
                        slots_nxt[count_nxt] = rel.cands[i];
                    end
                    count_nxt = count_nxt + 1'b1;
                end
            end
        end
    end

    // -----------------------------------------------------------------------
    // Output register
    // -----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_count <= '0;
            out_slots <= '0;
        end else begin
            // An input that only grew the run releases nothing and stays silent
            out_valid <= (count_nxt != '0);
            out_count <= count_nxt;
            out_slots <= slots_nxt;
        end
    end

    // Six candidates exist but the carry rule never releases more than four
    a_slot_capacity: assert property (@(posedge clk) disable iff (!arst_n)
        rel.cand_strobe |-> count_nxt <= `CARRY_SLOTS);

endmodule

`default_nettype wire

// File: tb_carry_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

// ---------------------------------------------------------------------------
// Expands output slots into bytes and compares each stream with its list
// ---------------------------------------------------------------------------
module tb_carry_checker (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        in_valid,
    input  logic                                        in_first,
    input  logic                                        in_final,
    input  logic                                        out_valid,
    input  logic [2:0]                                  out_count,
    input  carry_pkg::emit_slot_t [`CARRY_SLOTS-1:0]    out_slots
);
    import carry_pkg::*;

    logic [8*32-1:0]          names[$];
    int                       exp_len[$];
    logic [`CARRY_BYTE_W-1:0] exp_bytes[$];
    logic [`CARRY_BYTE_W-1:0] got[$];

    int exp_base    = 0;
    int done_count  = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int error_count = 0;
    bit stream_open = 1'b0;
    bit end_pending = 1'b0;

    task automatic add_stream(input logic [8*32-1:0] name, input int len);
        names.push_back(name);
        exp_len.push_back(len);
    endtask

    task automatic add_byte(input logic [`CARRY_BYTE_W-1:0] value);
        exp_bytes.push_back(value);
    endtask

    // A run slot stands for run_len copies of one byte value
    task automatic collect_slots();
        emit_slot_t s;
        // A strobe always carries between one and four slots
        if (out_count == '0 || out_count > `CARRY_SLOTS) begin
            $display("Output strobe carried an out_count of %0d", out_count);
            error_count++;
        end
        for (int i = 0; i < `CARRY_SLOTS; i++) begin
            s = out_slots[i];
            if (i < out_count) begin
                case (s.kind)
                    SLOT_LIT:    got.push_back(s.payload.lit_byte);
                    SLOT_RUN_FF: repeat (s.payload.run_len) got.push_back(8'hff);
                    SLOT_RUN_00: repeat (s.payload.run_len) got.push_back(8'h00);
                    default: begin
                        $display("Slot %0d is empty although out_count is %0d", i, out_count);
                        error_count++;
                    end
                endcase
            end else if (s.kind != SLOT_NONE) begin
                $display("Slot %0d holds data beyond out_count %0d", i, out_count);
                error_count++;
            end
        end
    endtask

    task automatic close_stream();
        int len;
        int first_diff;
        if (done_count >= names.size()) begin
            $display("A stream ended but no expected byte list is left for it");
            error_count++;
        end else begin
            len        = exp_len[done_count];
            first_diff = -1;
            for (int i = 0; i < len && i < got.size(); i++) begin
                if (first_diff < 0 && got[i] !== exp_bytes[exp_base + i]) begin
                    first_diff = i;
                end
            end
            if (first_diff >= 0) begin
                $display("Mismatch %0s byte %0d: expected 8'h%02h, actual 8'h%02h",
                         names[done_count], first_diff,
                         exp_bytes[exp_base + first_diff], got[first_diff]);
                fail_count++;
            end else if (got.size() != len) begin
                $display("Stream %0s expected %0d bytes but received %0d",
                         names[done_count], len, got.size());
                fail_count++;
            end else begin
                $display("ok   %0s: %0d bytes", names[done_count], len);
                pass_count++;
            end
            exp_base += len;
        end
        done_count++;
        got.delete();
    endtask

    // Sampled at the falling edge, half a cycle away from every change
    // The output seen here belongs to the input seen one falling edge earlier
    always @(negedge clk) begin
        if (!arst_n) begin
            stream_open = 1'b0;
            end_pending = 1'b0;
        end else begin
            if (out_valid) begin
                if (!stream_open) begin
                    $display("Output strobe arrived while no stream was open");
                    error_count++;
                end
                collect_slots();
            end else if (out_count != '0 || out_slots != '0) begin
                $display("Output slots are not empty while out_valid is low");
                error_count++;
            end
            if (end_pending) begin
                close_stream();
                stream_open = 1'b0;
            end
            if (in_valid && in_first) begin
                stream_open = 1'b1;
            end
            end_pending = in_valid && in_final;
        end
    end

endmodule

`default_nettype wire

// File: tb_carry_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "carry_settings.svh"

module tb_carry_top;
    import carry_pkg::*;

    typedef struct packed {
        logic       is_first;
        logic       is_final;
        logic [1:0] count;
        symbol_t    sym0;
        symbol_t    sym1;
    } in_line_t;

    logic                          clk;
    logic                          arst_n;
    logic                          in_valid;
    logic                          in_first;
    logic                          in_final;
    logic [1:0]                    in_count;
    symbol_t                       in_sym0;
    symbol_t                       in_sym1;
    logic                          out_valid;
    logic [2:0]                    out_count;
    emit_slot_t [`CARRY_SLOTS-1:0] out_slots;

    in_line_t    lines[$];
    int          n_streams    = 0;
    int          limit_cycles = 0;
    bit          loaded       = 1'b0;
    bit          load_ok;

    tb_clock_gen #(.period_ns(8.0)) clock0 (.clk(clk));

    carry_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_final  (in_final),
        .in_count  (in_count),
        .in_sym0   (in_sym0),
        .in_sym1   (in_sym1),
        .out_valid (out_valid),
        .out_count (out_count),
        .out_slots (out_slots)
    );

    tb_carry_checker checker0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_first  (in_first),
        .in_final  (in_final),
        .out_valid (out_valid),
        .out_count (out_count),
        .out_slots (out_slots)
    );

    // -----------------------------------------------------------------------
    // Pattern file reader
    // -----------------------------------------------------------------------
    task automatic load_patterns(output bit ok);
        int               fd;
        int               code;
        int               n;
        logic [8*32-1:0]  tok;
        logic [8*32-1:0]  name;
        logic [8*200-1:0] rest;
        logic [31:0]      f;
        logic [31:0]      l;
        logic [31:0]      c;
        logic [31:0]      s0;
        logic [31:0]      s1;
        logic [31:0]      b;
        in_line_t         rec;
        ok = 1'b0;
        fd = $fopen("carry_patterns.txt", "r");
        if (fd != 0) begin
            ok   = 1'b1;
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "I") begin
                    code         = $fscanf(fd, "%h %h %h %h %h", f, l, c, s0, s1);
                    rec.is_first = f[0];
                    rec.is_final = l[0];
                    rec.count    = c[1:0];
                    rec.sym0     = s0[8:0];
                    rec.sym1     = s1[8:0];
                    lines.push_back(rec);
                end else if (tok == "E") begin
                    code = $fscanf(fd, "%s %d", name, n);
                    checker0.add_stream(name, n);
                    n_streams++;
                    for (int i = 0; i < n; i++) begin
                        code = $fscanf(fd, "%h", b);
                        checker0.add_byte(b[7:0]);
                    end
                end else begin
                    $display("Unknown record %0s in the pattern file", tok);
                    ok = 1'b0;
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    // Each line is held for one cycle, then 0 to 3 idle cycles follow
    task automatic drive_lines();
        int gap;
        foreach (lines[k]) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_first = lines[k].is_first;
            in_final = lines[k].is_final;
            in_count = lines[k].count;
            in_sym0  = lines[k].sym0;
            in_sym1  = lines[k].sym1;
            gap      = $urandom % 4;
            if (gap != 0) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                in_first = 1'b0;
                in_final = 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_first = 1'b0;
        in_final = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_first  = 1'b0;
        in_final  = 1'b0;
        in_count  = 2'd1;
        in_sym0   = '0;
        in_sym1   = '0;
        void'($urandom(32'hc5c1));
        load_patterns(load_ok);
        if (!load_ok || n_streams == 0) begin
            $display("Could not read any test from carry_patterns.txt");
            $display("TEST FAIL");
        end else begin
            limit_cycles = 8 * lines.size() + 100;
            loaded       = 1'b1;
            apply_reset();
            drive_lines();
            wait (checker0.done_count >= n_streams);
            repeat (2) @(posedge clk);
            $display("Tests passed %0d, failed %0d, other errors %0d",
                     checker0.pass_count, checker0.fail_count, checker0.error_count);
            if (checker0.fail_count == 0 && checker0.error_count == 0 &&
                checker0.pass_count == n_streams) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

    // Watchdog sized from the number of input lines
    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d of %0d streams checked",
                 limit_cycles, checker0.done_count, n_streams);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock
module tb_clock_gen #(
    parameter real period_ns = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
